// File: filelist.f
hdl/spad_pkg.sv
hdl/dualport_ram.sv
hdl/port_arbiter.sv
hdl/collision_guard.sv
hdl/spad_top.sv
sim/tb_spad.sv

// File: sim/tb_spad.sv
////////////////////////////////////////////////////////////
// Testbench of the scratchpad with eight random clients
// A cycle model predicts grants, responses and collisions
// Inputs change 10 ns after a rising edge, checks run at 50 ns
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_spad;

    logic                                 clk0;
    logic                                 arst_n;
    logic [spad_pkg::n_clients-1:0]       req_0;
    logic [spad_pkg::n_clients-1:0]       req_1;
    spad_pkg::req_group_t                 client_req_0;
    spad_pkg::req_group_t                 client_req_1;
    logic [spad_pkg::n_clients-1:0]       grant_0;
    logic [spad_pkg::n_clients-1:0]       grant_1;
    spad_pkg::rsp_group_t                 client_rsp_0;
    spad_pkg::rsp_group_t                 client_rsp_1;
    logic                                 collision;

    // Client agents, indexed as group * 4 + client
    logic                                 act [0:7];
    logic                                 wr [0:7];
    logic [spad_pkg::addr_bits-1:0]       ad [0:7];
    logic [spad_pkg::data_bits-1:0]       wd [0:7];
    int                                   wait_cnt [0:7];

    // Reference model of the memory and of both arbiters
    logic [spad_pkg::data_bits-1:0]       mem_model [0:spad_pkg::n_entries-1];
    logic [spad_pkg::client_bits-1:0]     last_ptr [0:1];
    logic                                 g_found [0:1];
    logic [spad_pkg::client_bits-1:0]     g_win [0:1];

    // Responses and collision flag expected on the next cycle
    logic                                 pend_vld [0:1];
    logic [spad_pkg::client_bits-1:0]     pend_idx [0:1];
    logic [spad_pkg::data_bits-1:0]       pend_data [0:1];
    logic                                 pend_col;

    integer                               seed;
    int                                   n_checks;
    int                                   n_errors;
    int                                   n_timeouts;
    logic                                 narrow;

    spad_top dut0
    (
        .clk0         (clk0),
        .arst_n       (arst_n),
        .req_0        (req_0),
        .client_req_0 (client_req_0),
        .grant_0      (grant_0),
        .client_rsp_0 (client_rsp_0),
        .req_1        (req_1),
        .client_req_1 (client_req_1),
        .grant_1      (grant_1),
        .client_rsp_1 (client_rsp_1),
        .collision    (collision)
    );

    initial
    begin
        clk0 = 1'b0;
        forever
        begin
            #50 clk0 = ~clk0;
        end
    end

    // Compares one observed value with its expected value
    task check_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
        begin
            n_checks++;
            if (actual !== expected)
            begin
                n_errors++;
                $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected,
                         actual);
            end
        end
    endtask

    // Known content for every word, different for each address
    function automatic logic [63:0] fill_word(input logic [spad_pkg::addr_bits-1:0] a);
        fill_word = 64'hc3c3_0000_0000_3c3c ^ {27'h0, a, 27'h0, a};
    endfunction

    function automatic spad_pkg::mem_req_t make_req(input int i);
        spad_pkg::mem_req_t r;
        r.write = wr[i];
        r.addr = ad[i];
        r.wdata = wd[i];
        make_req = r;
    endfunction

    // An agent raises a request and keeps it until its grant is seen
    task post_request(input int g, input int c, input logic w,
                      input logic [spad_pkg::addr_bits-1:0] a, input logic [63:0] d);
        begin
            act[g * 4 + c] = 1'b1;
            wr[g * 4 + c] = w;
            ad[g * 4 + c] = a;
            wd[g * 4 + c] = d;
            wait_cnt[g * 4 + c] = 0;
        end
    endtask

    task drive_inputs;
        begin
            for (int c = 0; c < spad_pkg::n_clients; c++)
            begin
                req_0[c] = act[c];
                req_1[c] = act[c + 4];
                client_req_0[c] = make_req(c);
                client_req_1[c] = make_req(c + 4);
            end
        end
    endtask

    // Checks this cycle's outputs, then advances the model by one edge
    task check_cycle;
        logic [spad_pkg::client_bits-1:0] cand;
        logic [3:0]                       exp_gnt;
        logic                             col_now;
        logic                             eff_write;
        logic                             granted;
        spad_pkg::mem_rsp_t               rsp;
        int                               i;
        begin
            for (int g = 0; g < 2; g++)
            begin
                // Search starts right after the last winner and wraps around
                g_found[g] = 1'b0;
                g_win[g] = last_ptr[g];
                for (int k = 1; k <= spad_pkg::n_clients; k++)
                begin
                    cand = (last_ptr[g] + k) % spad_pkg::n_clients;
                    if (!g_found[g] && act[g * 4 + cand])
                    begin
                        g_found[g] = 1'b1;
                        g_win[g] = cand;
                    end
                end
                exp_gnt = '0;
                if (g_found[g])
                begin
                    exp_gnt[g_win[g]] = 1'b1;
                end
                check_value($sformatf("grant_%0d", g), exp_gnt, (g == 0) ? grant_0 : grant_1);
                for (int c = 0; c < spad_pkg::n_clients; c++)
                begin
                    rsp = (g == 0) ? client_rsp_0[c] : client_rsp_1[c];
                    check_value($sformatf("client_rsp_%0d[%0d].valid", g, c),
                                pend_vld[g] && (pend_idx[g] == c), rsp.valid);
                    if (pend_vld[g] && (pend_idx[g] == c))
                    begin
                        check_value($sformatf("client_rsp_%0d[%0d].rdata", g, c),
                                    pend_data[g], rsp.rdata);
                    end
                end
            end
            check_value("collision", pend_col, collision);

            // Both ports write one word, so port 1 falls back to a read
            col_now = g_found[0] && g_found[1] && wr[g_win[0]] && wr[4 + g_win[1]] &&
                      (ad[g_win[0]] == ad[4 + g_win[1]]);
            for (int g = 0; g < 2; g++)
            begin
                i = g * 4 + g_win[g];
                eff_write = wr[i] && !(g == 1 && col_now);
                pend_vld[g] = g_found[g];
                pend_idx[g] = g_win[g];
                pend_data[g] = eff_write ? wd[i] : mem_model[ad[i]];
            end
            pend_col = col_now;

            // Memory changes only after both reads took the old words
            if (g_found[1] && wr[4 + g_win[1]] && !col_now)
            begin
                mem_model[ad[4 + g_win[1]]] = wd[4 + g_win[1]];
            end
            if (g_found[0] && wr[g_win[0]])
            begin
                mem_model[ad[g_win[0]]] = wd[g_win[0]];
            end

            // Each agent releases its request once it samples its own grant
            for (i = 0; i < 8; i++)
            begin
                granted = (i < 4) ? grant_0[i % 4] : grant_1[i % 4];
                if (act[i] && granted)
                begin
                    act[i] = 1'b0;
                    wait_cnt[i] = 0;
                end
                else if (act[i])
                begin
                    wait_cnt[i]++;
                    // Three clients ahead at most, so a fourth lost cycle is starvation
                    if (wait_cnt[i] == 4)
                    begin
                        n_timeouts++;
                        $display("Timeout at %0t: client %0d of group %0d got no grant in %0d %s",
                                 $time, i % 4, i / 4, wait_cnt[i], "cycles");
                    end
                end
            end
            for (int g = 0; g < 2; g++)
            begin
                if (g_found[g])
                begin
                    last_ptr[g] = g_win[g];
                end
            end
        end
    endtask

    task run_cycle;
        begin
            @(posedge clk0);
            #10;
            drive_inputs();
            #40;
            check_cycle();
        end
    endtask

    // Runs cycles until every agent has been served, then one more for the last response
    task wait_idle(input int limit);
        int   cycles;
        logic busy;
        begin
            cycles = 0;
            busy = 1'b1;
            while (busy && cycles < limit)
            begin
                run_cycle();
                cycles++;
                busy = 1'b0;
                for (int i = 0; i < 8; i++)
                begin
                    busy = busy | act[i];
                end
            end
            if (busy)
            begin
                n_timeouts++;
                $display("Timeout at %0t: requests still pending after %0d cycles", $time, limit);
            end
            run_cycle();
        end
    endtask

    // Every idle agent raises a new request three times out of four
    task spawn_random;
        logic [spad_pkg::addr_bits-1:0] a;
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (!act[i] && (($random(seed) & 3) != 0))
                begin
                    a = narrow ? ($random(seed) & 3) : $random(seed);
                    post_request(i / 4, i % 4, $random(seed) & 1, a,
                                 {$random(seed), $random(seed)});
                end
            end
        end
    endtask

    initial
    begin
        seed = 83;
        n_checks = 0;
        n_errors = 0;
        n_timeouts = 0;
        narrow = 1'b0;
        arst_n = 1'b0;
        req_0 = '0;
        req_1 = '0;
        client_req_0 = '0;
        client_req_1 = '0;
        for (int i = 0; i < 8; i++)
        begin
            act[i] = 1'b0;
            wr[i] = 1'b0;
            ad[i] = '0;
            wd[i] = '0;
            wait_cnt[i] = 0;
        end
        for (int g = 0; g < 2; g++)
        begin
            last_ptr[g] = spad_pkg::n_clients - 1;
            pend_vld[g] = 1'b0;
            pend_idx[g] = '0;
            pend_data[g] = '0;
        end
        pend_col = 1'b0;
        repeat (5) @(posedge clk0);
        #10 arst_n = 1'b1;

        // Quiet after reset, with no request anywhere
        #40;
        check_value("grant_0 after reset", 4'h0, grant_0);
        check_value("grant_1 after reset", 4'h0, grant_1);
        check_value("collision after reset", 1'b0, collision);
        for (int c = 0; c < spad_pkg::n_clients; c++)
        begin
            check_value($sformatf("client_rsp_0[%0d].valid after reset", c), 1'b0,
                        client_rsp_0[c].valid);
            check_value($sformatf("client_rsp_1[%0d].valid after reset", c), 1'b0,
                        client_rsp_1[c].valid);
        end
        run_cycle();
        run_cycle();

        // Fill the whole RAM so that no read later returns unknown data
        for (int a = 0; a < spad_pkg::n_entries; a += 4)
        begin
            for (int c = 0; c < spad_pkg::n_clients; c++)
            begin
                post_request(0, c, 1'b1, a + c, fill_word(a + c));
            end
            wait_idle(16);
        end

        // All clients of both groups at once exercise the rotation
        for (int c = 0; c < spad_pkg::n_clients; c++)
        begin
            post_request(0, c, 1'b0, c * 3, '0);
            post_request(1, c, 1'b0, c * 5, '0);
        end
        wait_idle(16);

        // Port 1 reads a word that port 0 writes in the same cycle, then reads it again
        post_request(0, 1, 1'b1, 9, 64'h1111_2222_3333_4444);
        post_request(1, 2, 1'b0, 9, '0);
        wait_idle(8);
        post_request(1, 2, 1'b0, 9, '0);
        wait_idle(8);

        // Both ports write address 12, port 0 must win
        post_request(0, 2, 1'b1, 12, 64'haaaa_0000_aaaa_0000);
        post_request(1, 3, 1'b1, 12, 64'h5555_ffff_5555_ffff);
        wait_idle(8);
        post_request(1, 0, 1'b0, 12, '0);
        wait_idle(8);

        // Random traffic, with a narrow address range every other 500 cycles
        for (int n = 0; n < 4000; n++)
        begin
            narrow = ((n / 500) % 2) == 1;
            spawn_random();
            run_cycle();
        end
        wait_idle(20);

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/spad_top.sv
////////////////////////////////////////////////////////////
// Shared scratchpad of 32 words of 64 bits on one clock
// Two groups of four clients, one group per RAM port
// Fixed latency with grant in one cycle and response the next
// A port 0 write beats a port 1 write to the same address
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module spad_top
(
    input  logic                              clk0,
    input  logic                              arst_n,

    // Client group on RAM port 0
    input  logic [spad_pkg::n_clients-1:0]    req_0,
    input  spad_pkg::req_group_t              client_req_0,
    output logic [spad_pkg::n_clients-1:0]    grant_0,
    output spad_pkg::rsp_group_t              client_rsp_0,

    // Client group on RAM port 1
    input  logic [spad_pkg::n_clients-1:0]    req_1,
    input  spad_pkg::req_group_t              client_req_1,
    output logic [spad_pkg::n_clients-1:0]    grant_1,
    output spad_pkg::rsp_group_t              client_rsp_1,

    // Pulses together with the responses of a dropped port 1 write
    output logic                              collision
);

    // Port 0 path from its arbiter straight into the RAM
    spad_pkg::mem_req_t               port_req_0;
    logic                             port_en_0;
    logic [spad_pkg::data_bits-1:0]   port_rdata_0;

    // Port 1 path before and after the collision guard
    spad_pkg::mem_req_t               port_req_1;
    spad_pkg::mem_req_t               port_req_1_safe;
    logic                             port_en_1;
    logic [spad_pkg::data_bits-1:0]   port_rdata_1;

    // Arbiter for the port 0 client group
    port_arbiter arb_0
    (
        .clk0       (clk0),
        .arst_n     (arst_n),
        .req        (req_0),
        .client_req (client_req_0),
        .grant      (grant_0),
        .port_req   (port_req_0),
        .port_en    (port_en_0),
        .port_rdata (port_rdata_0),
        .client_rsp (client_rsp_0)
    );

    // Arbiter for the port 1 client group
    port_arbiter arb_1
    (
        .clk0       (clk0),
        .arst_n     (arst_n),
        .req        (req_1),
        .client_req (client_req_1),
        .grant      (grant_1),
        .port_req   (port_req_1),
        .port_en    (port_en_1),
        .port_rdata (port_rdata_1),
        .client_rsp (client_rsp_1)
    );

    // Watches both ports and strips a colliding port 1 write
    // Port enables pass around it unchanged
    collision_guard guard0
    (
        .clk0       (clk0),
        .arst_n     (arst_n),
        .req_a      (port_req_0),
        .en_a       (port_en_0),
        .req_b      (port_req_1),
        .en_b       (port_en_1),
        .req_b_safe (port_req_1_safe),
        .collision  (collision)
    );

    // Shared storage
    // Port 0 sees the raw arbiter request and port 1 the guarded one
    dualport_ram ram0
    (
        .clk0       (clk0),
        .req_a      (port_req_0),
        .en_a       (port_en_0),
        .rdata_a    (port_rdata_0),
        .req_b      (port_req_1_safe),
        .en_b       (port_en_1),
        .rdata_b    (port_rdata_1)
    );

endmodule

// File: hdl/collision_guard.sv
////////////////////////////////////////////////////////////
// Resolves same-cycle writes of both ports to one address
// Port 0 always wins and port 1 degrades to a read
// The collision pulse lines up with that access's responses
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module collision_guard
(
    input  logic                clk0,
    input  logic                arst_n,

    // Port 0 request, observed but never changed
    input  spad_pkg::mem_req_t  req_a,
    input  logic                en_a,

    // Port 1 request as the arbiter issued it
    input  spad_pkg::mem_req_t  req_b,
    input  logic                en_b,

    // Port 1 request as the RAM may safely perform it
    output spad_pkg::mem_req_t  req_b_safe,

    // One-cycle pulse a cycle after a write collision
    output logic                collision
);

    // Both ports are active and both write the same word in this cycle
    logic hit;

    // Registered copy of hit that forms the collision pulse
    logic collision_q;

    assign hit = en_a && en_b && req_a.write && req_b.write &&
                 (req_a.addr == req_b.addr);

    // Port 1 keeps its address and data but loses the write flag on a hit
    // The RAM then reads the old word on port 1 while port 0 writes it
    always_comb
    begin
        req_b_safe = req_b;
        req_b_safe.write = req_b.write && !hit;
    end

    // The RAM answers one cycle after the access
    // Delay the flag by the same amount so it matches the responses
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            collision_q <= 1'b0;
        end
        else
        begin
            collision_q <= hit;
        end
    end

    assign collision = collision_q;

endmodule

// File: hdl/port_arbiter.sv
////////////////////////////////////////////////////////////
// Round-robin arbiter of four clients onto one RAM port
// Grant is combinational and the response follows one cycle later
// Clients must hold req and their request until granted
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module port_arbiter
(
    input  logic                                  clk0,
    input  logic                                  arst_n,

    // Client side
    input  logic [spad_pkg::n_clients-1:0]        req,
    input  spad_pkg::req_group_t                  client_req,
    output logic [spad_pkg::n_clients-1:0]        grant,

    // RAM side
    output spad_pkg::mem_req_t                    port_req,
    output logic                                  port_en,
    input  logic [spad_pkg::data_bits-1:0]        port_rdata,

    // Responses routed back to the client granted one cycle earlier
    output spad_pkg::rsp_group_t                  client_rsp
);

    // Index of the most recently granted client
    // It rests at the last client after reset so client 0 wins first
    logic [spad_pkg::client_bits-1:0] last_q;

    // Result of the search in the current cycle
    logic [spad_pkg::client_bits-1:0] win_idx;
    logic                             found;

    // Candidate index while the search walks around the ring
    logic [spad_pkg::client_bits-1:0] cand;

    // Client that owns the response in flight, plus its valid bit
    logic [spad_pkg::client_bits-1:0] rsp_idx_q;
    logic                             rsp_vld_q;

    // Search the request bits starting at the client after the last winner
    // The last winner itself is looked at last, which gives it lowest priority
    // The index sum wraps naturally in client_bits
    always_comb
    begin
        found = 1'b0;
        win_idx = last_q;
        cand = last_q;
        for (int i = 1; i <= spad_pkg::n_clients; i++)
        begin
            cand = last_q + i[spad_pkg::client_bits-1:0];
            if (!found && req[cand])
            begin
                found = 1'b1;
                win_idx = cand;
            end
        end
    end

    // One-hot grant strobe for the winner of this cycle
    always_comb
    begin
        grant = '0;
        if (found)
        begin
            grant[win_idx] = 1'b1;
        end
    end

    // Forward the winning request to the RAM port
    // The request payload is don't-care while the port is idle
    assign port_req = client_req[win_idx];
    assign port_en = found;

    // The pointer only moves on a real grant
    // An idle cycle keeps the rotation where it was
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            last_q <= spad_pkg::client_bits'(spad_pkg::n_clients - 1);
        end
        else if (found)
        begin
            last_q <= win_idx;
        end
    end

    // Remember who was granted so the RAM read data can be steered back
    // The RAM registers its output on the same edge, so both line up
    always_ff @(posedge clk0 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_idx_q <= '0;
            rsp_vld_q <= 1'b0;
        end
        else
        begin
            rsp_vld_q <= found;
            if (found)
            begin
                rsp_idx_q <= win_idx;
            end
        end
    end

    // Every client sees the shared read data
    // Only the client granted last cycle sees the valid strobe
    always_comb
    begin
        for (int c = 0; c < spad_pkg::n_clients; c++)
        begin
            client_rsp[c].valid = rsp_vld_q && (rsp_idx_q == c[spad_pkg::client_bits-1:0]);
            client_rsp[c].rdata = port_rdata;
        end
    end

endmodule

// File: hdl/dualport_ram.sv
////////////////////////////////////////////////////////////
// True dual-port block RAM on one clock, no reset
// A writing port returns its own new data
// A cross-port read of a word written that cycle sees old data
// Same-address writes on both ports must never reach it
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module dualport_ram
(
    input  logic                             clk0,

    input  spad_pkg::mem_req_t               req_a,
    input  logic                             en_a,
    output logic [spad_pkg::data_bits-1:0]   rdata_a,

    input  spad_pkg::mem_req_t               req_b,
    input  logic                             en_b,
    output logic [spad_pkg::data_bits-1:0]   rdata_b
);

    // Storage array, left without reset so it maps onto block RAM
    logic [spad_pkg::data_bits-1:0] mem [0:spad_pkg::n_entries-1];

    // Port A
    // A write stores the word and also registers it as read data
    // Nonblocking reads see the word as it was before this edge
    always @(posedge clk0)
    begin
        if (en_a)
        begin
            if (req_a.write)
            begin
                mem[req_a.addr] <= req_a.wdata;
                rdata_a <= req_a.wdata;
            end
            else
            begin
                rdata_a <= mem[req_a.addr];
            end
        end
    end

    // Port B works the same way as port A
    // The collision guard has already turned a same-address write into a read
    always @(posedge clk0)
    begin
        if (en_b)
        begin
            if (req_b.write)
            begin
                mem[req_b.addr] <= req_b.wdata;
                rdata_b <= req_b.wdata;
            end
            else
            begin
                rdata_b <= mem[req_b.addr];
            end
        end
    end

endmodule

// File: hdl/spad_pkg.sv
////////////////////////////////////////////////////////////
// Sizes and payload types of the shared scratchpad
// The design is built for one RAM size set here
// Each port group always has four clients
////////////////////////////////////////////////////////////

package spad_pkg;

    // Number of RAM words
    localparam int n_entries = 32;

    // Address width that covers every RAM word
    localparam int addr_bits = $clog2(n_entries);

    // Width of one data word
    localparam int data_bits = 64;

    // Number of peer clients that share one RAM port
    localparam int n_clients = 4;

    // Width of a client index inside one group
    localparam int client_bits = $clog2(n_clients);

    // One access toward a RAM port
    // A read is any request with the write flag low
    typedef struct packed {
        logic                 write;
        logic [addr_bits-1:0] addr;
        logic [data_bits-1:0] wdata;
    } mem_req_t;

    // One response back to a client
    // The valid strobe lasts a single cycle
    typedef struct packed {
        logic                 valid;
        logic [data_bits-1:0] rdata;
    } mem_rsp_t;

    // Requests of the four clients of one group
    typedef mem_req_t [n_clients-1:0] req_group_t;

    // Responses to the four clients of one group
    typedef mem_rsp_t [n_clients-1:0] rsp_group_t;

endpackage
